// File: src/eth_tx_pkg.sv
`default_nettype none

package eth_tx_pkg;

	//////////////////////////////////////////////////
	// Widths

	// APB byte address and data word
	typedef logic [11:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// One frame byte
	typedef logic [7:0] byte_t;

	// Frame length in bytes, up to 2047
	typedef logic [10:0] frame_len_t;

	//////////////////////////////////////////////////
	// Register map

	// Bit 0 is the link state, read only
	localparam apb_addr_t reg_stat    = 12'h000;
	// Any written value closes the current frame
	localparam apb_addr_t reg_commit  = 12'h020;
	// Expected length of the frame being written
	localparam apb_addr_t reg_length  = 12'h040;
	// Single data word
	localparam apb_addr_t reg_tx_word = 12'h060;
	// Every address from here upward is data too
	localparam apb_addr_t reg_tx_buf  = 12'h080;

	//////////////////////////////////////////////////
	// Buses between the stages

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
		logic [3:0] pstrb;
	} apb_req_t;

	typedef struct packed {
		logic      pready;
		apb_data_t prdata;
		logic      pslverr;
	} apb_rsp_t;

	// Lanes counts the bytes that follow byte 0
	typedef struct packed {
		logic       valid;
		apb_data_t  data;
		logic [1:0] lanes;
	} word_wr_t;

	typedef struct packed {
		logic       len_valid;
		frame_len_t len;
		logic       commit;
	} ctl_wr_t;

	typedef struct packed {
		logic  valid;
		byte_t data;
	} byte_wr_t;

	typedef struct packed {
		logic       valid;
		frame_len_t len;
	} frame_commit_t;

	typedef struct packed {
		logic  start;
		logic  data_valid;
		byte_t data;
	} eth_tx_t;

endpackage

`default_nettype wire

// File: src/apb_tx_regs.sv
`default_nettype none

module apb_tx_regs (
	input  wire                    apb,
	input  wire                    arst_n,
	input  wire eth_tx_pkg::apb_req_t req,
	output eth_tx_pkg::apb_rsp_t   rsp,
	input  wire                    link_up,
	input  wire                    busy,
	input  wire                    almost_full,
	output eth_tx_pkg::word_wr_t   word_wr,
	output eth_tx_pkg::ctl_wr_t    ctl_wr
);

	import eth_tx_pkg::*;

	//////////////////////////////////////////////////
	// Access decode

	logic       access;
	logic       done;
	logic       is_data;
	logic [1:0] lanes_next;

	// Strobe registers for the serializer
	logic       word_valid_q;
	apb_data_t  word_data_q;
	logic [1:0] word_lanes_q;
	logic       len_valid_q;
	frame_len_t len_q;
	logic       commit_q;

	always_comb begin
		access = req.psel && req.penable;
		// Hold off while bytes drain or storage is nearly full
		done = access && !busy && !almost_full;
		is_data = (req.paddr == reg_tx_word) || (req.paddr >= reg_tx_buf);

		// Highest strobe lane sets the byte count
		if (req.pstrb[3]) begin
			lanes_next = 2'd3;
		end else if (req.pstrb[2]) begin
			lanes_next = 2'd2;
		end else if (req.pstrb[1]) begin
			lanes_next = 2'd1;
		end else begin
			lanes_next = 2'd0;
		end
	end

	// Readback and error response
	always_comb begin
		rsp.pready  = done;
		rsp.prdata  = '0;
		rsp.pslverr = 1'b0;
		if (done) begin
			if (req.pwrite) begin
				// Status is read only
				rsp.pslverr = (req.paddr == reg_stat);
			end else if (req.paddr == reg_stat) begin
				rsp.prdata = apb_data_t'(link_up);
			end else begin
				// Everything else is write only
				rsp.pslverr = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Strobes toward the serializer

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			word_valid_q <= 1'b0;
			len_valid_q  <= 1'b0;
			commit_q     <= 1'b0;
		end else begin
			word_valid_q <= done && req.pwrite && is_data;
			len_valid_q  <= done && req.pwrite && (req.paddr == reg_length);
			commit_q     <= done && req.pwrite && (req.paddr == reg_commit);
		end
	end

	// Payload follows the strobe into the same cycle
	always_ff @(posedge apb) begin
		word_data_q  <= req.pwdata;
		word_lanes_q <= lanes_next;
		len_q        <= req.pwdata[10:0];
	end

	assign word_wr = '{valid: word_valid_q, data: word_data_q, lanes: word_lanes_q};
	assign ctl_wr  = '{len_valid: len_valid_q, len: len_q, commit: commit_q};

endmodule

`default_nettype wire

// File: src/tx_byte_serializer.sv
`default_nettype none

module tx_byte_serializer (
	input  wire                         apb,
	input  wire                         arst_n,
	input  wire                         link_up,
	input  wire eth_tx_pkg::word_wr_t   word_wr,
	input  wire eth_tx_pkg::ctl_wr_t    ctl_wr,
	output logic                        busy,
	output eth_tx_pkg::byte_wr_t        byte_wr,
	output eth_tx_pkg::frame_commit_t   frame_commit
);

	import eth_tx_pkg::*;

	// Up to three bytes waiting behind byte 0
	logic [23:0] pend_data;
	logic [1:0]  pend_cnt;

	// Bytes already issued and the length software expects
	frame_len_t wr_cnt;
	frame_len_t exp_len;

	logic       byte_valid_q;
	byte_t      byte_data_q;
	logic       commit_valid_q;
	frame_len_t commit_len_q;

	logic  want;
	logic  room;
	logic  emit;
	byte_t next_byte;

	//////////////////////////////////////////////////
	// Byte selection

	always_comb begin
		// New word wins since APB stalls until pending bytes are gone
		want      = word_wr.valid || (pend_cnt != 2'd0);
		next_byte = word_wr.valid ? word_wr.data[7:0] : pend_data[7:0];
		// Drop anything past the expected length
		room      = (wr_cnt < exp_len);
		emit      = want && room;
	end

	assign busy = (pend_cnt != 2'd0);

	//////////////////////////////////////////////////
	// Control state

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			pend_cnt       <= 2'd0;
			wr_cnt         <= '0;
			exp_len        <= '0;
			byte_valid_q   <= 1'b0;
			commit_valid_q <= 1'b0;
		end else if (!link_up) begin
			// Link down flushes the partial frame
			pend_cnt       <= 2'd0;
			wr_cnt         <= '0;
			exp_len        <= '0;
			byte_valid_q   <= 1'b0;
			commit_valid_q <= 1'b0;
		end else begin
			byte_valid_q   <= emit;
			commit_valid_q <= 1'b0;

			if (emit) begin
				wr_cnt <= wr_cnt + 1'b1;
			end

			// Load a word or step through the one in hand
			if (word_wr.valid) begin
				pend_cnt <= word_wr.lanes;
			end else if (pend_cnt != 2'd0) begin
				pend_cnt <= pend_cnt - 1'b1;
			end

			if (ctl_wr.len_valid) begin
				exp_len <= ctl_wr.len;
			end

			// Commit queues the length unless nothing was written
			if (ctl_wr.commit) begin
				commit_valid_q <= (wr_cnt != '0);
				wr_cnt         <= '0;
				exp_len        <= '0;
				pend_cnt       <= 2'd0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Payload registers

	always_ff @(posedge apb) begin
		if (want) begin
			byte_data_q <= next_byte;
		end
		// Lowest lane goes out first
		if (word_wr.valid) begin
			pend_data <= word_wr.data[31:8];
		end else begin
			pend_data <= {8'h00, pend_data[23:8]};
		end
		if (ctl_wr.commit) begin
			commit_len_q <= wr_cnt;
		end
	end

	assign byte_wr      = '{valid: byte_valid_q, data: byte_data_q};
	assign frame_commit = '{valid: commit_valid_q, len: commit_len_q};

endmodule

`default_nettype wire

// File: src/tx_frame_fifo.sv
`default_nettype none

module tx_frame_fifo #(
	parameter int DATA_DEPTH = 4096,
	parameter int LEN_DEPTH  = 32
) (
	input  wire                            apb,
	input  wire                            arst_n,
	input  wire                            link_up,
	input  wire eth_tx_pkg::byte_wr_t      byte_wr,
	input  wire eth_tx_pkg::frame_commit_t frame_commit,
	output logic                           almost_full,
	input  wire                            data_pop,
	input  wire                            hdr_pop,
	output eth_tx_pkg::byte_t              data_out,
	output eth_tx_pkg::frame_len_t         len_out,
	output logic                           hdr_empty
);

	import eth_tx_pkg::*;

	localparam int DAW = $clog2(DATA_DEPTH);
	localparam int LAW = $clog2(LEN_DEPTH);

	//////////////////////////////////////////////////
	// Storage and pointers

	byte_t          data_mem [DATA_DEPTH];
	logic [DAW-1:0] data_wp;
	logic [DAW-1:0] data_rp;
	logic [DAW:0]   data_cnt;

	frame_len_t     len_mem [LEN_DEPTH];
	logic [LAW-1:0] len_wp;
	logic [LAW-1:0] len_rp;
	logic [LAW:0]   len_cnt;

	logic data_we;
	logic data_re;
	logic len_we;
	logic len_re;

	// Writes into a full buffer and pops from an empty one are ignored
	assign data_we = link_up && byte_wr.valid && (data_cnt != (DAW+1)'(DATA_DEPTH));
	assign data_re = link_up && data_pop && (data_cnt != '0);
	assign len_we  = link_up && frame_commit.valid && (len_cnt != (LAW+1)'(LEN_DEPTH));
	assign len_re  = link_up && hdr_pop && (len_cnt != '0);

	assign hdr_empty = (len_cnt == '0);

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			data_wp     <= '0;
			data_rp     <= '0;
			data_cnt    <= '0;
			len_wp      <= '0;
			len_rp      <= '0;
			len_cnt     <= '0;
			almost_full <= 1'b0;
		end else if (!link_up) begin
			// Flush both buffers
			data_wp     <= '0;
			data_rp     <= '0;
			data_cnt    <= '0;
			len_wp      <= '0;
			len_rp      <= '0;
			len_cnt     <= '0;
			almost_full <= 1'b0;
		end else begin
			// Circular pointers wrap at the depth
			if (data_we) begin
				data_wp <= (data_wp == DAW'(DATA_DEPTH - 1)) ? '0 : data_wp + 1'b1;
			end
			if (data_re) begin
				data_rp <= (data_rp == DAW'(DATA_DEPTH - 1)) ? '0 : data_rp + 1'b1;
			end
			if (len_we) begin
				len_wp <= (len_wp == LAW'(LEN_DEPTH - 1)) ? '0 : len_wp + 1'b1;
			end
			if (len_re) begin
				len_rp <= (len_rp == LAW'(LEN_DEPTH - 1)) ? '0 : len_rp + 1'b1;
			end

			data_cnt <= data_cnt + (DAW+1)'(data_we) - (DAW+1)'(data_re);
			len_cnt  <= len_cnt + (LAW+1)'(len_we) - (LAW+1)'(len_re);

			// One slot or fewer left in either buffer
			almost_full <= (data_cnt >= (DAW+1)'(DATA_DEPTH - 1)) ||
				(len_cnt >= (LAW+1)'(LEN_DEPTH - 1));
		end
	end

	//////////////////////////////////////////////////
	// Memory and registered read data

	always_ff @(posedge apb) begin
		if (data_we) begin
			data_mem[data_wp] <= byte_wr.data;
		end
		if (len_we) begin
			len_mem[len_wp] <= frame_commit.len;
		end
		// Read data appears the cycle after the pop
		if (data_re) begin
			data_out <= data_mem[data_rp];
		end
		if (len_re) begin
			len_out <= len_mem[len_rp];
		end
	end

endmodule

`default_nettype wire

// File: src/tx_frame_sender.sv
`default_nettype none

module tx_frame_sender (
	input  wire                         apb,
	input  wire                         arst_n,
	input  wire                         tx_ready,
	input  wire                         hdr_empty,
	input  wire eth_tx_pkg::frame_len_t len_in,
	input  wire eth_tx_pkg::byte_t      data_in,
	output logic                        hdr_pop,
	output logic                        data_pop,
	output eth_tx_pkg::eth_tx_t         tx
);

	import eth_tx_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		POP,
		SEND
	} state_t;

	state_t     state;
	// Bytes popped so far in this frame
	frame_len_t byte_cnt;
	logic       start_q;
	logic       valid_q;

	//////////////////////////////////////////////////
	// Pops

	// MAC readiness only matters between frames
	assign hdr_pop  = (state == IDLE) && !hdr_empty && tx_ready;
	// One byte per cycle for the whole frame
	assign data_pop = (state == SEND);

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			state    <= IDLE;
			byte_cnt <= '0;
			start_q  <= 1'b0;
			valid_q  <= 1'b0;
		end else begin
			start_q <= 1'b0;
			// Byte data lags its pop by one cycle
			valid_q <= data_pop;
			case (state)
				IDLE: begin
					if (hdr_pop) begin
						state <= POP;
					end
				end
				POP: begin
					// Length is valid now
					byte_cnt <= '0;
					if (len_in != '0) begin
						start_q <= 1'b1;
						state   <= SEND;
					end else begin
						state <= IDLE;
					end
				end
				SEND: begin
					byte_cnt <= byte_cnt + 1'b1;
					if (byte_cnt == len_in - 1'b1) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Output bus
	assign tx = '{start: start_q, data_valid: valid_q, data: data_in};

endmodule

`default_nettype wire

// File: src/eth_tx_buffer.sv
`default_nettype none

module eth_tx_buffer #(
	parameter int DATA_DEPTH = 4096,
	parameter int LEN_DEPTH  = 32
) (
	input  wire                       apb,
	input  wire                       arst_n,
	input  wire eth_tx_pkg::apb_req_t req,
	output eth_tx_pkg::apb_rsp_t      rsp,
	input  wire                       link_up,
	input  wire                       tx_ready,
	output eth_tx_pkg::eth_tx_t       tx
);

	import eth_tx_pkg::*;

	//////////////////////////////////////////////////
	// Stage interconnect

	word_wr_t      word_wr;
	ctl_wr_t       ctl_wr;
	byte_wr_t      byte_wr;
	frame_commit_t frame_commit;
	logic          busy;
	logic          almost_full;
	logic          data_pop;
	logic          hdr_pop;
	logic          hdr_empty;
	byte_t         fifo_data;
	frame_len_t    fifo_len;

	// Register front end
	apb_tx_regs u_regs (
		.apb         (apb),
		.arst_n      (arst_n),
		.req         (req),
		.rsp         (rsp),
		.link_up     (link_up),
		.busy        (busy),
		.almost_full (almost_full),
		.word_wr     (word_wr),
		.ctl_wr      (ctl_wr)
	);

	// Words to bytes
	tx_byte_serializer u_ser (
		.apb          (apb),
		.arst_n       (arst_n),
		.link_up      (link_up),
		.word_wr      (word_wr),
		.ctl_wr       (ctl_wr),
		.busy         (busy),
		.byte_wr      (byte_wr),
		.frame_commit (frame_commit)
	);

	// Byte and length storage
	tx_frame_fifo #(
		.DATA_DEPTH (DATA_DEPTH),
		.LEN_DEPTH  (LEN_DEPTH)
	) u_fifo (
		.apb          (apb),
		.arst_n       (arst_n),
		.link_up      (link_up),
		.byte_wr      (byte_wr),
		.frame_commit (frame_commit),
		.almost_full  (almost_full),
		.data_pop     (data_pop),
		.hdr_pop      (hdr_pop),
		.data_out     (fifo_data),
		.len_out      (fifo_len),
		.hdr_empty    (hdr_empty)
	);

	// Frame output
	tx_frame_sender u_send (
		.apb       (apb),
		.arst_n    (arst_n),
		.tx_ready  (tx_ready),
		.hdr_empty (hdr_empty),
		.len_in    (fifo_len),
		.data_in   (fifo_data),
		.hdr_pop   (hdr_pop),
		.data_pop  (data_pop),
		.tx        (tx)
	);

endmodule

`default_nettype wire

// File: tests/tb_eth_tx_tasks.svh
`ifndef TB_ETH_TX_TASKS_SVH
`define TB_ETH_TX_TASKS_SVH

//////////////////////////////////////////////////
// Value checks

// Immediate check of one value against its expected value
task automatic expect_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
	checks++;
	assert (exp === act) else begin
		$display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
		errors++;
	end
endtask

// Bytes in a word, counted up to the highest strobe lane
function automatic int strobe_bytes(input logic [3:0] strb);
	int n;
	n = 1;
	for (int i = 1; i < 4; i++) begin
		if (strb[i]) begin
			n = i + 1;
		end
	end
	return n;
endfunction

//////////////////////////////////////////////////
// APB transfers

// Setup phase, access phase, then wait for pready
task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
	input logic [3:0] strb, output apb_data_t rdata, output logic err);
	int n;
	req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata, pstrb: strb};
	@(posedge apb);
	req.penable <= 1'b1;
	@(posedge apb);
	n = 0;
	while (!rsp.pready && n < apb_timeout) begin
		n++;
		@(posedge apb);
	end
	if (!rsp.pready) begin
		$display("APB access to address %h got no pready within %0d cycles", addr, apb_timeout);
		errors++;
	end
	rdata = rsp.prdata;
	err   = rsp.pslverr;
	// Back to idle in the cycle after completion
	req <= '0;
endtask

task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic [3:0] strb,
	output logic err);
	apb_data_t unused;
	apb_access(1'b1, addr, data, strb, unused, err);
endtask

task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
	apb_access(1'b0, addr, '0, 4'h0, data, err);
endtask

//////////////////////////////////////////////////
// Frame building

task automatic set_length(input int len);
	logic err;
	apb_write(reg_length, apb_data_t'(len), 4'hF, err);
	expect_equal("length write pslverr", 0, err);
	staged.delete();
	cur_len = len;
endtask

// Random word, strobed bytes staged lowest lane first
task automatic write_word(input apb_addr_t addr, input logic [3:0] strb);
	apb_data_t word;
	logic      err;
	int        nb;
	word = $urandom;
	nb   = strobe_bytes(strb);
	apb_write(addr, word, strb, err);
	expect_equal("data write pslverr", 0, err);
	for (int i = 0; i < nb; i++) begin
		staged.push_back(word[8*i +: 8]);
	end
endtask

// Only bytes up to the expected length make it into the frame
task automatic commit_frame();
	int   n;
	logic err;
	n = (staged.size() < cur_len) ? staged.size() : cur_len;
	apb_write(reg_commit, 32'h1, 4'hF, err);
	expect_equal("commit pslverr", 0, err);
	for (int i = 0; i < n; i++) begin
		exp_bytes.push_back(staged[i]);
	end
	// Empty commit queues nothing
	if (n != 0) begin
		exp_lens.push_back(n);
	end
	staged.delete();
	cur_len = 0;
endtask

`endif

// File: tests/tb_eth_tx_buffer.sv
`default_nettype none

module tb_eth_tx_buffer;

	import eth_tx_pkg::*;

	localparam int apb_timeout   = 200;
	localparam int frame_timeout = 600;

	logic     apb;
	logic     arst_n;
	apb_req_t req;
	apb_rsp_t rsp;
	logic     link_up;
	logic     tx_ready;
	eth_tx_t  tx;

	int          errors;
	int          checks;
	string       test_name;
	int          cur_len;

	// Written bytes of the open frame
	byte_t staged[$];
	// Expected and captured frames as flat bytes with a length per frame
	byte_t exp_bytes[$];
	int    exp_lens[$];
	byte_t cap_bytes[$];
	int    cap_lens[$];

	apb_data_t rdata;
	logic      err;

	`include "tb_eth_tx_tasks.svh"

	eth_tx_buffer #(
		.DATA_DEPTH (64),
		.LEN_DEPTH  (4)
	) dut0 (
		.apb      (apb),
		.arst_n   (arst_n),
		.req      (req),
		.rsp      (rsp),
		.link_up  (link_up),
		.tx_ready (tx_ready),
		.tx       (tx)
	);

	always #4 apb = ~apb;

	//////////////////////////////////////////////////
	// Output capture

	// Each start opens a new frame, taken mid cycle while the bus is stable
	always @(negedge apb) begin
		if (arst_n) begin
			if (tx.start) begin
				cap_lens.push_back(0);
			end
			if (tx.data_valid) begin
				assert (cap_lens.size() != 0) else begin
					$display("Data byte seen with no start pulse before it");
					errors++;
				end
				if (cap_lens.size() != 0) begin
					cap_lens[cap_lens.size() - 1] = cap_lens[cap_lens.size() - 1] + 1;
					cap_bytes.push_back(tx.data);
				end
			end
		end
	end

	// First byte comes one cycle after start
	assert property (@(posedge apb) disable iff (!arst_n) tx.start |=> tx.data_valid)
		else begin
			$display("Start pulse with no data byte in the next cycle");
			errors++;
		end

	// Error only ever on a completing access
	assert property (@(posedge apb) disable iff (!arst_n) rsp.pslverr |-> rsp.pready)
		else begin
			$display("Slave error raised outside a completing access");
			errors++;
		end

	//////////////////////////////////////////////////
	// Frame waits and comparison

	function automatic bit frames_complete();
		if (cap_lens.size() < exp_lens.size()) begin
			return 1'b0;
		end
		if (exp_lens.size() == 0) begin
			return 1'b1;
		end
		return cap_lens[exp_lens.size() - 1] >= exp_lens[exp_lens.size() - 1];
	endfunction

	task automatic wait_frames();
		int n;
		n = 0;
		while (!frames_complete() && n < frame_timeout) begin
			n++;
			@(posedge apb);
		end
		if (!frames_complete()) begin
			$display("%s: frames did not leave within %0d cycles", test_name, frame_timeout);
			errors++;
		end
		// Catch trailing bytes of the last frame
		repeat (4) @(posedge apb);
	endtask

	task automatic check_frames();
		expect_equal("frame count", exp_lens.size(), cap_lens.size());
		for (int f = 0; f < exp_lens.size() && f < cap_lens.size(); f++) begin
			expect_equal($sformatf("frame %0d length", f), exp_lens[f], cap_lens[f]);
		end
		expect_equal("byte count", exp_bytes.size(), cap_bytes.size());
		for (int i = 0; i < exp_bytes.size() && i < cap_bytes.size(); i++) begin
			expect_equal($sformatf("byte %0d", i), exp_bytes[i], cap_bytes[i]);
		end
		exp_bytes.delete();
		exp_lens.delete();
		cap_bytes.delete();
		cap_lens.delete();
	endtask

	// Nothing may leave during the window
	task automatic expect_no_frames(input int cycles);
		repeat (cycles) @(posedge apb);
		expect_equal("frames while held", 0, cap_lens.size());
	endtask

	//////////////////////////////////////////////////
	// Scenarios

	initial begin
		void'($urandom(22));
		errors    = 0;
		checks    = 0;
		cur_len   = 0;
		test_name = "reset";
		apb       = 1'b0;
		arst_n    = 1'b0;
		req       = '0;
		link_up   = 1'b1;
		tx_ready  = 1'b1;
		repeat (3) @(posedge apb);
		arst_n <= 1'b1;
		@(posedge apb);
		expect_equal("pready", 0, rsp.pready);
		expect_equal("tx start", 0, tx.start);
		expect_equal("tx data_valid", 0, tx.data_valid);

		// Link state in bit 0 at both levels
		test_name = "status";
		apb_read(reg_stat, rdata, err);
		expect_equal("link up read", 1, rdata);
		expect_equal("link up pslverr", 0, err);
		link_up <= 1'b0;
		@(posedge apb);
		apb_read(reg_stat, rdata, err);
		expect_equal("link down read", 0, rdata);
		expect_equal("link down pslverr", 0, err);
		link_up <= 1'b1;
		@(posedge apb);

		test_name = "errors";
		apb_write(reg_stat, 32'h1, 4'hF, err);
		expect_equal("status write pslverr", 1, err);
		apb_read(reg_length, rdata, err);
		expect_equal("length read pslverr", 1, err);
		apb_read(reg_commit, rdata, err);
		expect_equal("commit read pslverr", 1, err);
		apb_read(reg_tx_buf, rdata, err);
		expect_equal("buffer read pslverr", 1, err);

		test_name = "full_words";
		set_length(12);
		write_word(reg_tx_word, 4'hF);
		write_word(reg_tx_buf, 4'hF);
		write_word(reg_tx_buf + 12'h004, 4'hF);
		commit_frame();
		wait_frames();
		check_frames();

		// Bytes past the length are dropped
		test_name = "truncation";
		set_length(6);
		write_word(reg_tx_word, 4'hF);
		write_word(reg_tx_word, 4'hF);
		commit_frame();
		wait_frames();
		check_frames();

		test_name = "partial_strobes";
		set_length(3);
		write_word(reg_tx_word, 4'h3);
		write_word(reg_tx_word, 4'hF);
		commit_frame();
		wait_frames();
		check_frames();

		// Three frames held back and then released in order
		test_name = "ordering";
		tx_ready <= 1'b0;
		set_length(5);
		write_word(reg_tx_word, 4'hF);
		write_word(reg_tx_word, 4'h1);
		commit_frame();
		set_length(8);
		write_word(reg_tx_buf + 12'h010, 4'hF);
		write_word(reg_tx_buf + 12'h014, 4'hF);
		commit_frame();
		set_length(4);
		write_word(reg_tx_word, 4'hF);
		commit_frame();
		expect_no_frames(32);
		tx_ready <= 1'b1;
		wait_frames();
		check_frames();

		// Link drop discards committed and partial frames
		test_name = "flush";
		tx_ready <= 1'b0;
		set_length(8);
		write_word(reg_tx_word, 4'hF);
		write_word(reg_tx_word, 4'hF);
		commit_frame();
		set_length(6);
		write_word(reg_tx_word, 4'hF);
		link_up <= 1'b0;
		repeat (3) @(posedge apb);
		link_up <= 1'b1;
		@(posedge apb);
		exp_bytes.delete();
		exp_lens.delete();
		tx_ready <= 1'b1;
		expect_no_frames(32);
		set_length(7);
		write_word(reg_tx_word, 4'hF);
		write_word(reg_tx_buf, 4'h7);
		commit_frame();
		wait_frames();
		check_frames();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+tests
src/eth_tx_pkg.sv
src/apb_tx_regs.sv
src/tx_byte_serializer.sv
src/tx_frame_fifo.sv
src/tx_frame_sender.sv
src/eth_tx_buffer.sv
tests/tb_eth_tx_buffer.sv

// File: Bender.yml
package:
  name: eth_tx_buffer

sources:
  - src/eth_tx_pkg.sv
  - src/apb_tx_regs.sv
  - src/tx_byte_serializer.sv
  - src/tx_frame_fifo.sv
  - src/tx_frame_sender.sv
  - src/eth_tx_buffer.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_eth_tx_buffer.sv
